// File: Makefile
SIM = obj_dir/Vtb_bus

all: run

$(SIM): bus.f bus_consts.svh $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/1ps -f bus.f --top-module tb_bus -o Vtb_bus

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: bus.f
+incdir+.
bus_pkg.sv
bus_arbiter.sv
bus_addr_decoder.sv
bus_router.sv
bus.sv
tb_bus_targets.sv
tb_bus.sv

// File: bus.sv
`timescale 1ns/1ps

module bus
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // Initiator 1
    input  logic  init1_req,
    input  addr_t init1_addr,
    input  data_t init1_wdata,
    input  logic  init1_rw,
    output logic  init1_grant,
    output data_t init1_rdata,
    output logic  init1_ack,

    // Initiator 2
    input  logic  init2_req,
    input  addr_t init2_addr,
    input  data_t init2_wdata,
    input  logic  init2_rw,
    output logic  init2_grant,
    output data_t init2_rdata,
    output logic  init2_ack,

    // Target 1
    output logic  target1_sel,
    output addr_t target1_addr,
    output data_t target1_wdata,
    output logic  target1_rw,
    input  data_t target1_rdata,
    input  logic  target1_ack,

    // Target 2
    output logic  target2_sel,
    output addr_t target2_addr,
    output data_t target2_wdata,
    output logic  target2_rw,
    input  data_t target2_rdata,
    input  logic  target2_ack
);

    init_sel_t   owner;
    target_sel_t decode_sel;
    addr_t       decode_offset;
    logic        xfer_done;

    bus_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .init1_req   (init1_req),
        .init2_req   (init2_req),
        .xfer_done   (xfer_done),
        .init1_grant (init1_grant),
        .init2_grant (init2_grant),
        .owner       (owner)
    );

    bus_addr_decoder u_addr_decoder (
        .owner         (owner),
        .init1_addr    (init1_addr),
        .init2_addr    (init2_addr),
        .decode_sel    (decode_sel),
        .decode_offset (decode_offset)
    );

    bus_router u_router (
        .clk           (clk),
        .rst_n         (rst_n),
        .owner         (owner),
        .decode_sel    (decode_sel),
        .decode_offset (decode_offset),
        .init1_wdata   (init1_wdata),
        .init1_rw      (init1_rw),
        .init2_wdata   (init2_wdata),
        .init2_rw      (init2_rw),
        .target1_sel   (target1_sel),
        .target1_addr  (target1_addr),
        .target1_wdata (target1_wdata),
        .target1_rw    (target1_rw),
        .target2_sel   (target2_sel),
        .target2_addr  (target2_addr),
        .target2_wdata (target2_wdata),
        .target2_rw    (target2_rw),
        .target1_ack   (target1_ack),
        .target1_rdata (target1_rdata),
        .target2_ack   (target2_ack),
        .target2_rdata (target2_rdata),
        .init1_ack     (init1_ack),
        .init1_rdata   (init1_rdata),
        .init2_ack     (init2_ack),
        .init2_rdata   (init2_rdata),
        .xfer_done     (xfer_done)
    );

endmodule

// File: bus_addr_decoder.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_addr_decoder
    import bus_pkg::*;
(
    input  init_sel_t   owner,
    input  addr_t       init1_addr,
    input  addr_t       init2_addr,
    output target_sel_t decode_sel,
    output addr_t       decode_offset
);

    addr_t sel_addr;
    addr_t off1;
    addr_t off2;
    logic  hit1;
    logic  hit2;

    always_comb begin
        case (owner)
            init_1:  sel_addr = init1_addr;
            init_2:  sel_addr = init2_addr;
            default: sel_addr = '0;
        endcase
    end

    // Offset wraps below the base, so one compare covers both window edges
    assign off1 = sel_addr - addr_t'(`BUS_T1_BASE);
    assign off2 = sel_addr - addr_t'(`BUS_T2_BASE);
    assign hit1 = (owner != init_none) && (off1 < addr_t'(`BUS_T1_SIZE));
    assign hit2 = (owner != init_none) && (off2 < addr_t'(`BUS_T2_SIZE));

    always_comb begin
        decode_sel    = target_none;
        decode_offset = '0;
        if (hit1) begin
            decode_sel    = target_1;
            decode_offset = off1;
        end else if (hit2) begin
            decode_sel    = target_2;
            decode_offset = off2;
        end
    end

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init1_req,
    input  logic      init2_req,
    input  logic      xfer_done,
    output logic      init1_grant,
    output logic      init2_grant,
    output init_sel_t owner
);

    init_sel_t last_owner;
    init_sel_t next_pick;

    // Initiator 1 first, unless it had the last turn and initiator 2 waits
    always_comb begin
        next_pick = init_none;
        if (init1_req && !(init2_req && last_owner == init_1)) begin
            next_pick = init_1;
        end else if (init2_req) begin
            next_pick = init_2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner      <= init_none;
            last_owner <= init_none;
        end else if (owner == init_none) begin
            owner <= next_pick;
            if (next_pick != init_none) begin
                last_owner <= next_pick;
            end
        end else if (xfer_done) begin
            // Back to idle for one cycle before the next grant
            owner <= init_none;
        end
    end

    assign init1_grant = (owner == init_1);
    assign init2_grant = (owner == init_2);

endmodule

// File: bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Bus widths
`define BUS_ADDR_W 16
`define BUS_DATA_W 8

// Target 1 window
`define BUS_T1_BASE 16'h0000
`define BUS_T1_SIZE 16'd2048

// Target 2 window
`define BUS_T2_BASE 16'h4000
`define BUS_T2_SIZE 16'd4096

`endif

// File: bus_pkg.sv
`include "bus_consts.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_DATA_W-1:0] data_t;

    // Owning initiator
    typedef enum logic [1:0] {
        init_none = 2'b00,
        init_1    = 2'b01,
        init_2    = 2'b10
    } init_sel_t;

    // Selected target
    typedef enum logic [1:0] {
        target_none = 2'b00,
        target_1    = 2'b01,
        target_2    = 2'b10
    } target_sel_t;

endpackage

// File: bus_router.sv
`timescale 1ns/1ps

module bus_router
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  init_sel_t   owner,
    input  target_sel_t decode_sel,
    input  addr_t       decode_offset,

    input  data_t       init1_wdata,
    input  logic        init1_rw,
    input  data_t       init2_wdata,
    input  logic        init2_rw,

    output logic        target1_sel,
    output addr_t       target1_addr,
    output data_t       target1_wdata,
    output logic        target1_rw,
    output logic        target2_sel,
    output addr_t       target2_addr,
    output data_t       target2_wdata,
    output logic        target2_rw,

    input  logic        target1_ack,
    input  data_t       target1_rdata,
    input  logic        target2_ack,
    input  data_t       target2_rdata,

    output logic        init1_ack,
    output data_t       init1_rdata,
    output logic        init2_ack,
    output data_t       init2_rdata,
    output logic        xfer_done
);

    target_sel_t held_target;
    init_sel_t   held_owner;
    data_t       fwd_wdata;
    logic        fwd_rw;
    logic        resp_ack;
    data_t       resp_rdata;

    // Latch target and owner once per transfer, release on the target's ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_target <= target_none;
            held_owner  <= init_none;
        end else if (held_target == target_none) begin
            if (owner != init_none && decode_sel != target_none) begin
                held_target <= decode_sel;
                held_owner  <= owner;
            end
        end else if (resp_ack) begin
            held_target <= target_none;
            held_owner  <= init_none;
        end
    end

    always_comb begin
        case (held_owner)
            init_1: begin
                fwd_wdata = init1_wdata;
                fwd_rw    = init1_rw;
            end
            init_2: begin
                fwd_wdata = init2_wdata;
                fwd_rw    = init2_rw;
            end
            default: begin
                fwd_wdata = '0;
                fwd_rw    = 1'b0;
            end
        endcase
    end

    // Payload goes to both targets, sel qualifies it
    assign target1_sel   = (held_target == target_1);
    assign target1_addr  = decode_offset;
    assign target1_wdata = fwd_wdata;
    assign target1_rw    = fwd_rw;
    assign target2_sel   = (held_target == target_2);
    assign target2_addr  = decode_offset;
    assign target2_wdata = fwd_wdata;
    assign target2_rw    = fwd_rw;

    always_comb begin
        case (held_target)
            target_1: begin
                resp_ack   = target1_ack;
                resp_rdata = target1_rdata;
            end
            target_2: begin
                resp_ack   = target2_ack;
                resp_rdata = target2_rdata;
            end
            default: begin
                resp_ack   = 1'b0;
                resp_rdata = '0;
            end
        endcase
    end

    // Response only reaches the owner, the other side sees zeros
    assign init1_ack   = resp_ack && (held_owner == init_1);
    assign init1_rdata = (held_owner == init_1) ? resp_rdata : '0;
    assign init2_ack   = resp_ack && (held_owner == init_2);
    assign init2_rdata = (held_owner == init_2) ? resp_rdata : '0;

    assign xfer_done = resp_ack;

endmodule

// File: tb_bus.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module tb_bus
    import bus_pkg::*;
();

    localparam int XFERS_TOTAL = 78;

    logic  clk;
    logic  rst_n;
    logic  init1_req, init1_rw, init1_grant, init1_ack;
    logic  init2_req, init2_rw, init2_grant, init2_ack;
    addr_t init1_addr, init2_addr, target1_addr, target2_addr;
    data_t init1_wdata, init1_rdata, init2_wdata, init2_rdata;
    logic  target1_sel, target1_rw, target1_ack, target2_sel, target2_rw, target2_ack;
    data_t target1_wdata, target1_rdata, target2_wdata, target2_rdata;

    data_t ref_mem [addr_t];
    int    issued [1:2];
    int    ack_count [1:2];
    int    grant_order [$];
    logic  grant1_q, grant2_q;
    int    checks;
    int    errors;
    int    err_mark;

    bus dut (.*);

    tb_bus_targets targets (.*);

    function automatic data_t fill_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h3c;
    endfunction

    // Last byte written to an address or else its power-up pattern
    function automatic data_t ref_read(input addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    function automatic int window_of(input addr_t a);
        return (int'(a) < int'(`BUS_T1_BASE) + int'(`BUS_T1_SIZE)) ? 1 : 2;
    endfunction

    function automatic addr_t window_base(input int w);
        return (w == 1) ? addr_t'(`BUS_T1_BASE) : addr_t'(`BUS_T2_BASE);
    endfunction

    task automatic check(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string label);
        $display("%s: %s", label, (errors == err_mark) ? "pass" : "fail");
        err_mark = errors;
    endtask

    // Drive one transfer after the edge and hold it until ack, then release req
    task automatic xfer(input int id, input addr_t a, input logic rw, input data_t wd);
        @(posedge clk);
        #1;
        if (id == 1) begin
            init1_req   = 1'b1;
            init1_addr  = a;
            init1_wdata = wd;
            init1_rw    = rw;
        end else begin
            init2_req   = 1'b1;
            init2_addr  = a;
            init2_wdata = wd;
            init2_rw    = rw;
        end
        issued[id]++;
        do @(negedge clk); while (!((id == 1) ? init1_ack : init2_ack));
        @(posedge clk);
        #1;
        if (id == 1) begin
            init1_req = 1'b0;
        end else begin
            init2_req = 1'b0;
        end
    endtask

    // Small offsets so the two initiators hit the same bytes often
    task automatic rand_xfer(input int id);
        addr_t a;
        logic  rw;
        data_t wd;
        a  = addr_t'($urandom_range(31, 0));
        a  = a + window_base(int'($urandom_range(2, 1)));
        rw = ($urandom_range(1, 0) == 1);
        wd = data_t'($urandom_range(255, 0));
        xfer(id, a, rw, wd);
    endtask

    task automatic observe_ack(input int id, input logic req, input logic ack, input logic rw,
                               input addr_t a, input data_t wd, input data_t rd);
        if (ack) begin
            ack_count[id]++;
            if (!req) begin
                errors++;
                $display("Initiator %0d saw an acknowledge with no request pending", id);
            end
            if (rw) begin
                ref_mem[a] = wd;
            end else begin
                check($sformatf("init%0d_rdata", id), int'(rd), int'(ref_read(a)));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Compares at the falling edge where DUT outputs have settled
    initial begin
        addr_t sel_addr;
        int    win;
        grant1_q = 1'b0;
        grant2_q = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                observe_ack(1, init1_req, init1_ack, init1_rw, init1_addr, init1_wdata,
                            init1_rdata);
                observe_ack(2, init2_req, init2_ack, init2_rw, init2_addr, init2_wdata,
                            init2_rdata);
                if (target1_sel || target2_sel) begin
                    sel_addr = init1_grant ? init1_addr : init2_addr;
                    win      = window_of(sel_addr);
                    check("target1_sel", int'(target1_sel), int'(win == 1));
                    check("target2_sel", int'(target2_sel), int'(win == 2));
                    check((win == 1) ? "target1_addr" : "target2_addr",
                          int'((win == 1) ? target1_addr : target2_addr),
                          int'(sel_addr - window_base(win)));
                end
                if (init1_grant && !grant1_q) begin
                    grant_order.push_back(1);
                end
                if (init2_grant && !grant2_q) begin
                    grant_order.push_back(2);
                end
                grant1_q = init1_grant;
                grant2_q = init2_grant;
            end
        end
    end

    initial begin
        repeat (200 * XFERS_TOTAL) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a transfer never finished",
                 200 * XFERS_TOTAL);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int n1_acks;
        void'($urandom(32'h92c2));
        rst_n       = 1'b0;
        init1_req   = 1'b0;
        init1_addr  = '0;
        init1_wdata = '0;
        init1_rw    = 1'b0;
        init2_req   = 1'b0;
        init2_addr  = '0;
        init2_wdata = '0;
        init2_rw    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        xfer(1, addr_t'(`BUS_T1_BASE) + 16'h0012, 1'b1, 8'ha7);
        xfer(1, addr_t'(`BUS_T2_BASE) + 16'h0345, 1'b1, 8'h3c);
        xfer(1, addr_t'(`BUS_T1_BASE) + 16'h0012, 1'b0, 8'h00);
        xfer(1, addr_t'(`BUS_T2_BASE) + 16'h0345, 1'b0, 8'h00);
        report_test("[1] initiator 1 write and read back");

        n1_acks = ack_count[1];
        xfer(2, addr_t'(`BUS_T1_BASE) + 16'h07ff, 1'b1, 8'h5a);
        xfer(2, addr_t'(`BUS_T2_BASE) + 16'h0fff, 1'b1, 8'hc3);
        xfer(2, addr_t'(`BUS_T1_BASE) + 16'h07ff, 1'b0, 8'h00);
        xfer(2, addr_t'(`BUS_T2_BASE) + 16'h0fff, 1'b0, 8'h00);
        check("init1_ack count", ack_count[1] - n1_acks, 0);
        report_test("[2] initiator 2 write and read back");

        grant_order.delete();
        fork
            repeat (3) xfer(1, addr_t'(`BUS_T1_BASE) + 16'h0020, 1'b1, 8'h11);
            repeat (3) xfer(2, addr_t'(`BUS_T2_BASE) + 16'h0020, 1'b1, 8'h22);
        join
        check("grant count", grant_order.size(), 6);
        foreach (grant_order[i]) begin
            check($sformatf("grant_order[%0d]", i), grant_order[i], (i % 2 == 0) ? 1 : 2);
        end
        // Initiator 1 had the last turn, so a joint request on an idle bus goes to 2
        xfer(1, addr_t'(`BUS_T1_BASE) + 16'h0021, 1'b1, 8'h33);
        grant_order.delete();
        fork
            xfer(1, addr_t'(`BUS_T1_BASE) + 16'h0022, 1'b1, 8'h44);
            xfer(2, addr_t'(`BUS_T2_BASE) + 16'h0022, 1'b1, 8'h55);
        join
        check("grant count after turn", grant_order.size(), 2);
        foreach (grant_order[i]) begin
            check($sformatf("grant_order[%0d]", i), grant_order[i], (i == 0) ? 2 : 1);
        end
        report_test("[3] simultaneous requests and alternation");

        fork
            xfer(1, addr_t'(`BUS_T2_BASE) + 16'h0123, 1'b1, 8'h5e);
            begin
                do @(negedge clk); while (!target2_sel);
                check("target2_addr", int'(target2_addr), 'h123);
                check("target1_sel", int'(target1_sel), 0);
            end
        join
        report_test("[4] target 2 window decode");

        fork
            repeat (30) rand_xfer(1);
            repeat (30) rand_xfer(2);
        join
        check("init1 ack count", ack_count[1], issued[1]);
        check("init2 ack count", ack_count[2], issued[2]);
        report_test("[5] random mixed traffic");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb_bus_targets.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module tb_bus_targets
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  target1_sel,
    input  addr_t target1_addr,
    input  data_t target1_wdata,
    input  logic  target1_rw,
    output logic  target1_ack,
    output data_t target1_rdata,
    input  logic  target2_sel,
    input  addr_t target2_addr,
    input  data_t target2_wdata,
    input  logic  target2_rw,
    output logic  target2_ack,
    output data_t target2_rdata
);

    data_t mem1 [`BUS_T1_SIZE];
    data_t mem2 [`BUS_T2_SIZE];

    // Power-up contents follow the absolute address
    function automatic data_t fill_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h3c;
    endfunction

    // Target 1 answers after 0 to 3 idle cycles
    initial begin
        target1_ack   = 1'b0;
        target1_rdata = '0;
        for (int i = 0; i < int'(`BUS_T1_SIZE); i++) begin
            mem1[i[10:0]] = fill_byte(addr_t'(int'(`BUS_T1_BASE) + i));
        end
        forever begin
            @(negedge clk);
            if (rst_n && target1_sel) begin
                repeat ($urandom_range(3, 0)) @(posedge clk);
                @(posedge clk);
                #1;
                target1_ack = 1'b1;
                if (target1_rw) begin
                    mem1[target1_addr[10:0]] = target1_wdata;
                end else begin
                    target1_rdata = mem1[target1_addr[10:0]];
                end
                @(posedge clk);
                #1;
                target1_ack   = 1'b0;
                target1_rdata = '0;
            end
        end
    end

    // Target 2, same behavior over the larger window
    initial begin
        target2_ack   = 1'b0;
        target2_rdata = '0;
        for (int i = 0; i < int'(`BUS_T2_SIZE); i++) begin
            mem2[i[11:0]] = fill_byte(addr_t'(int'(`BUS_T2_BASE) + i));
        end
        forever begin
            @(negedge clk);
            if (rst_n && target2_sel) begin
                repeat ($urandom_range(3, 0)) @(posedge clk);
                @(posedge clk);
                #1;
                target2_ack = 1'b1;
                if (target2_rw) begin
                    mem2[target2_addr[11:0]] = target2_wdata;
                end else begin
                    target2_rdata = mem2[target2_addr[11:0]];
                end
                @(posedge clk);
                #1;
                target2_ack   = 1'b0;
                target2_rdata = '0;
            end
        end
    end

endmodule
